// File: src/lsu_defs.svh
// LSU shared definitions

`ifndef LSU_DEFS_SVH
`define LSU_DEFS_SVH

// Number of load/store ports sharing the data memory.
`define LSU_PORT_NUM 2

// Physical address width in bits.
`define PADDR_W 32

// Data word width in bits.
`define XLEN 32

// Word index width into the data memory, 64 words.
`define DMEM_IDX_W 6

`endif

// File: src/lsu_pkg.sv
// LSU types package

`include "lsu_defs.svh"

package lsu_pkg;

  // Request operation carried by each port.
  typedef enum logic [1:0] {
    OP_LOAD  = 2'b00,  // Plain word load.
    OP_STORE = 2'b01,  // Plain word store.
    OP_LR    = 2'b10,  // Load-reserved.
    OP_SC    = 2'b11   // Store-conditional.
  } lsu_op_e;

  // Word-aligned address split for the memory path.
  typedef struct packed {
    logic [`PADDR_W-`DMEM_IDX_W-3:0] tag;     // Upper bits, ignored by the memory.
    logic [`DMEM_IDX_W-1:0]          idx;     // Word index.
    logic [1:0]                      offset;  // Byte offset within the word.
  } paddr_fields_t;

  // Physical address, viewed whole or as fields.
  typedef union packed {
    logic [`PADDR_W-1:0] raw;     // Used for reservation compare.
    paddr_fields_t       fields;  // Used for memory indexing.
  } paddr_u;

endpackage

// File: src/bit_oh_or.sv
// One-hot OR selector

`timescale 1ns/100ps

module bit_oh_or
  import lsu_pkg::*;
#(
  parameter type T     = paddr_u,
  parameter int  WORDS = 2
) (
  input  logic [WORDS-1:0] i_oh,
  input  T                 i_data [WORDS],
  output T                 o_selected
);

  logic [$bits(T)-1:0] w_acc;

  // OR of all words whose select bit is set, no priority chain.
  always_comb begin
    w_acc = '0;
    for (int i = 0; i < WORDS; i++) begin
      if (i_oh[i]) begin
        w_acc = w_acc | i_data[i];
      end
    end
  end

  assign o_selected = T'(w_acc);

  // More than one select bit would merge two words.
  always_comb begin
    assert ($isunknown(i_oh) || $onehot0(i_oh))
      else $error("bit_oh_or: select is not one-hot");
  end

endmodule

// File: src/lsu_lrsc.sv
// LR/SC reservation unit

`timescale 1ns/100ps
`include "lsu_defs.svh"

module lsu_lrsc
  import lsu_pkg::*;
(
  input  logic                     i_clk,
  input  logic                     i_reset_n,
  input  logic [`LSU_PORT_NUM-1:0] i_lr_valid,
  input  logic [`LSU_PORT_NUM-1:0] i_sc_valid,
  input  paddr_u                   i_paddr [`LSU_PORT_NUM],
  output logic                     o_sc_success
);

  logic                r_resv_valid;  // Reservation held.
  logic [`PADDR_W-1:0] r_resv_addr;   // Reserved address, raw view.

  paddr_u w_lr_paddr_sel;
  paddr_u w_sc_paddr_sel;

  bit_oh_or #(
    .T     (paddr_u),
    .WORDS (`LSU_PORT_NUM)
  ) u_lr_addr_sel (
    .i_oh       (i_lr_valid),
    .i_data     (i_paddr),
    .o_selected (w_lr_paddr_sel)
  );

  bit_oh_or #(
    .T     (paddr_u),
    .WORDS (`LSU_PORT_NUM)
  ) u_sc_addr_sel (
    .i_oh       (i_sc_valid),
    .i_data     (i_paddr),
    .o_selected (w_sc_paddr_sel)
  );

  // LR sets the reservation, any SC drops it. LR wins.
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_resv_valid <= 1'b0;
      r_resv_addr  <= '0;
    end else if (|i_lr_valid) begin
      r_resv_valid <= 1'b1;
      r_resv_addr  <= w_lr_paddr_sel.raw;
    end else if (|i_sc_valid) begin
      r_resv_valid <= 1'b0;
    end
  end

  assign o_sc_success = r_resv_valid & (r_resv_addr == w_sc_paddr_sel.raw);  // Same cycle.

  // Only one port may touch the reservation per cycle.
  a_one_lrsc : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    $onehot0({i_lr_valid, i_sc_valid}))
    else $error("lsu_lrsc: more than one LR/SC in a cycle");

  // An LR always leaves a live reservation behind.
  a_lr_sets : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (|i_lr_valid) |=> r_resv_valid)
    else $error("lsu_lrsc: reservation not set after LR");

endmodule

// File: src/lsu_port.sv
// LSU port request and response stage

`timescale 1ns/100ps
`include "lsu_defs.svh"

module lsu_port
  import lsu_pkg::*;
(
  input  logic                   i_clk,
  input  logic                   i_reset_n,

  // Request side.
  input  logic                   i_req_valid,
  input  lsu_op_e                i_req_op,
  input  paddr_u                 i_req_addr,
  input  logic [`XLEN-1:0]       i_req_wdata,

  // Reservation unit.
  output logic                   o_lr_valid,
  output logic                   o_sc_valid,
  output paddr_u                 o_paddr,
  input  logic                   i_sc_success,

  // Memory read.
  output logic [`DMEM_IDX_W-1:0] o_rd_idx,
  input  logic [`XLEN-1:0]       i_rd_data,

  // Memory write.
  output logic                   o_wr_en,
  output logic [`DMEM_IDX_W-1:0] o_wr_idx,
  output logic [`XLEN-1:0]       o_wr_data,

  // Response side.
  output logic                   o_resp_valid,
  output logic [`XLEN-1:0]       o_resp_data
);

  logic             w_is_store;
  logic             w_is_lr;
  logic             w_is_sc;
  logic [`XLEN-1:0] w_resp_data;

  logic             r_resp_valid;
  logic [`XLEN-1:0] r_resp_data;

  // Operation decode, qualified by the strobe.
  assign w_is_store = i_req_valid & (i_req_op == OP_STORE);
  assign w_is_lr    = i_req_valid & (i_req_op == OP_LR);
  assign w_is_sc    = i_req_valid & (i_req_op == OP_SC);

  // Reservation strobes.
  assign o_lr_valid = w_is_lr;
  assign o_sc_valid = w_is_sc;
  assign o_paddr    = i_req_addr;

  // Memory access uses the field view.
  assign o_rd_idx  = i_req_addr.fields.idx;
  assign o_wr_idx  = i_req_addr.fields.idx;
  assign o_wr_data = i_req_wdata;
  assign o_wr_en   = w_is_store | (w_is_sc & i_sc_success);  // SC writes only on success.

  // Response word before the register.
  always_comb begin
    unique case (i_req_op)
      OP_LOAD,
      OP_LR:    w_resp_data = i_rd_data;                         // Old memory word.
      OP_SC:    w_resp_data = {{(`XLEN-1){1'b0}}, ~i_sc_success};  // 0 on success.
      default:  w_resp_data = '0;                                // Store.
    endcase
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_resp_valid <= 1'b0;
      r_resp_data  <= '0;
    end else begin
      r_resp_valid <= i_req_valid;
      if (i_req_valid) begin
        r_resp_data <= w_resp_data;  // Hold last response otherwise.
      end
    end
  end

  assign o_resp_valid = r_resp_valid;
  assign o_resp_data  = r_resp_data;

  // Each request gets exactly one response, one cycle later.
  a_resp_latency : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    1'b1 |=> (o_resp_valid == $past(i_req_valid)))
    else $error("lsu_port: response strobe out of step with request");

endmodule

// File: src/lsu_dmem.sv
// Multi-port data memory

`timescale 1ns/100ps
`include "lsu_defs.svh"

module lsu_dmem (
  input  logic                     i_clk,

  // Combinational read ports.
  input  logic [`DMEM_IDX_W-1:0]   i_rd_idx  [`LSU_PORT_NUM],
  output logic [`XLEN-1:0]         o_rd_data [`LSU_PORT_NUM],

  // One write port per LSU port.
  input  logic [`LSU_PORT_NUM-1:0] i_wr_en,
  input  logic [`DMEM_IDX_W-1:0]   i_wr_idx  [`LSU_PORT_NUM],
  input  logic [`XLEN-1:0]         i_wr_data [`LSU_PORT_NUM]
);

  localparam int DEPTH = 1 << `DMEM_IDX_W;

  logic [`XLEN-1:0] r_mem [DEPTH];  // Word storage.

  // Reads see the contents before this cycle's writes.
  for (genvar p = 0; p < `LSU_PORT_NUM; p++) begin : g_rd
    assign o_rd_data[p] = r_mem[i_rd_idx[p]];
  end

  // Writes go in ascending port order so the highest port wins a collision.
  always_ff @(posedge i_clk) begin
    for (int p = 0; p < `LSU_PORT_NUM; p++) begin
      if (i_wr_en[p]) begin
        r_mem[i_wr_idx[p]] <= i_wr_data[p];
      end
    end
  end

endmodule

// File: src/lsu_top.sv
// LSU subsystem top

`timescale 1ns/100ps
`include "lsu_defs.svh"

module lsu_top
  import lsu_pkg::*;
(
  input  logic                     i_clk,
  input  logic                     i_reset_n,
  input  logic [`LSU_PORT_NUM-1:0] i_req_valid,
  input  lsu_op_e                  i_req_op    [`LSU_PORT_NUM],
  input  paddr_u                   i_req_addr  [`LSU_PORT_NUM],
  input  logic [`XLEN-1:0]         i_req_wdata [`LSU_PORT_NUM],
  output logic [`LSU_PORT_NUM-1:0] o_resp_valid,
  output logic [`XLEN-1:0]         o_resp_data [`LSU_PORT_NUM]
);

  logic [`LSU_PORT_NUM-1:0] w_lr_valid;
  logic [`LSU_PORT_NUM-1:0] w_sc_valid;
  paddr_u                   w_paddr   [`LSU_PORT_NUM];
  logic                     w_sc_success;  // Shared by all ports.

  logic [`DMEM_IDX_W-1:0]   w_rd_idx  [`LSU_PORT_NUM];
  logic [`XLEN-1:0]         w_rd_data [`LSU_PORT_NUM];
  logic [`LSU_PORT_NUM-1:0] w_wr_en;
  logic [`DMEM_IDX_W-1:0]   w_wr_idx  [`LSU_PORT_NUM];
  logic [`XLEN-1:0]         w_wr_data [`LSU_PORT_NUM];

  for (genvar p = 0; p < `LSU_PORT_NUM; p++) begin : g_port
    lsu_port u_port (
      .i_clk        (i_clk),
      .i_reset_n    (i_reset_n),
      .i_req_valid  (i_req_valid[p]),
      .i_req_op     (i_req_op[p]),
      .i_req_addr   (i_req_addr[p]),
      .i_req_wdata  (i_req_wdata[p]),
      .o_lr_valid   (w_lr_valid[p]),
      .o_sc_valid   (w_sc_valid[p]),
      .o_paddr      (w_paddr[p]),
      .i_sc_success (w_sc_success),
      .o_rd_idx     (w_rd_idx[p]),
      .i_rd_data    (w_rd_data[p]),
      .o_wr_en      (w_wr_en[p]),
      .o_wr_idx     (w_wr_idx[p]),
      .o_wr_data    (w_wr_data[p]),
      .o_resp_valid (o_resp_valid[p]),
      .o_resp_data  (o_resp_data[p])
    );
  end

  lsu_dmem u_dmem (
    .i_clk     (i_clk),
    .i_rd_idx  (w_rd_idx),
    .o_rd_data (w_rd_data),
    .i_wr_en   (w_wr_en),
    .i_wr_idx  (w_wr_idx),
    .i_wr_data (w_wr_data)
  );

  lsu_lrsc u_lrsc (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_lr_valid   (w_lr_valid),
    .i_sc_valid   (w_sc_valid),
    .i_paddr      (w_paddr),
    .o_sc_success (w_sc_success)
  );

endmodule

// File: testbench/tb_lsu_top.sv
// LSU subsystem testbench

`timescale 1ns/100ps
`include "lsu_defs.svh"

module tb_lsu_top
  import lsu_pkg::*;
();

  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 5;
  localparam int RAND_SEED    = 92;
  localparam int MAX_LINES    = 64;
  localparam int PORT_FIELDS  = 5;                                // Flag, op, addr, wdata, expect.
  localparam int FIELDS       = 1 + PORT_FIELDS * `LSU_PORT_NUM;  // Test number comes first.

  // Port flag column of the cases file.
  localparam int FLAG_IDLE       = 0;
  localparam int FLAG_RAND_STORE = 2;  // Store with random data.
  localparam int FLAG_RAND_LOAD  = 3;  // Load of a randomly written word.

  logic                     clk = 1'b0;
  logic                     reset_n;
  logic [`LSU_PORT_NUM-1:0] req_valid;
  lsu_op_e                  req_op    [`LSU_PORT_NUM];
  paddr_u                   req_addr  [`LSU_PORT_NUM];
  logic [`XLEN-1:0]         req_wdata [`LSU_PORT_NUM];
  logic [`LSU_PORT_NUM-1:0] resp_valid;
  logic [`XLEN-1:0]         resp_data [`LSU_PORT_NUM];

  logic [31:0]              case_words [MAX_LINES*FIELDS];
  logic [`XLEN-1:0]         shadow     [1 << `DMEM_IDX_W];  // Random words stored so far.
  logic [`LSU_PORT_NUM-1:0] exp_valid;
  logic [`XLEN-1:0]         exp_data   [`LSU_PORT_NUM];

  int n_lines      = 0;
  int cycle_count  = 0;
  int cycle_limit  = 0;
  int test_errors  = 0;
  int total_errors = 0;
  int tests_run    = 0;
  int tests_failed = 0;

  lsu_top DUT (
    .i_clk        (clk),
    .i_reset_n    (reset_n),
    .i_req_valid  (req_valid),
    .i_req_op     (req_op),
    .i_req_addr   (req_addr),
    .i_req_wdata  (req_wdata),
    .o_resp_valid (resp_valid),
    .o_resp_data  (resp_data)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // Run limit, set once the cases are loaded.
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      $display("Timeout: the run did not end within %0d cycles", cycle_limit);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] case_field(input int line, input int port, input int col);
    return case_words[line * FIELDS + 1 + port * PORT_FIELDS + col];
  endfunction

  task automatic drive_line(input int line);
    int          flag;
    logic [31:0] op_word;
    for (int p = 0; p < `LSU_PORT_NUM; p++) begin
      flag             = int'(case_field(line, p, 0));
      op_word          = case_field(line, p, 1);
      req_valid[p]     = (flag != FLAG_IDLE);
      req_op[p]        = lsu_op_e'(op_word[1:0]);
      req_addr[p].raw  = case_field(line, p, 2);
      if (flag == FLAG_IDLE || flag == FLAG_RAND_STORE) begin
        req_wdata[p] = $urandom();  // Padding or random store data.
      end else begin
        req_wdata[p] = case_field(line, p, 3);
      end
      exp_valid[p] = req_valid[p];
      if (flag == FLAG_RAND_LOAD) begin
        exp_data[p] = shadow[req_addr[p].fields.idx];  // Old word, before this line's stores.
      end else begin
        exp_data[p] = case_field(line, p, 4);
      end
    end
    // Ascending order, the higher port wins a same-word write.
    for (int p = 0; p < `LSU_PORT_NUM; p++) begin
      flag = int'(case_field(line, p, 0));
      if (flag == FLAG_RAND_STORE) begin
        shadow[req_addr[p].fields.idx] = req_wdata[p];
      end
    end
  endtask

  task automatic check_line(input int line);
    for (int p = 0; p < `LSU_PORT_NUM; p++) begin
      if (resp_valid[p] !== exp_valid[p]) begin
        $display("CHECK FAILED at time %0t: line %0d port %0d resp_valid %b, expected %b",
                 $time, line, p, resp_valid[p], exp_valid[p]);
        test_errors++;
      end else if (exp_valid[p] && resp_data[p] !== exp_data[p]) begin
        $display("CHECK FAILED at time %0t: line %0d port %0d resp_data %h, expected %h",
                 $time, line, p, resp_data[p], exp_data[p]);
        test_errors++;
      end
    end
  endtask

  task automatic check_reset_state();
    for (int p = 0; p < `LSU_PORT_NUM; p++) begin
      if (resp_valid[p] !== 1'b0 || resp_data[p] !== '0) begin
        $display("CHECK FAILED at time %0t: port %0d response not cleared in reset",
                 $time, p);
        test_errors++;
      end
    end
  endtask

  task automatic report_test(input string name);
    tests_run++;
    total_errors += test_errors;
    if (test_errors == 0) begin
      $display("%s: pass", name);
    end else begin
      $display("%s: FAIL with %0d errors", name, test_errors);
      tests_failed++;
    end
    test_errors = 0;
  endtask

  // Checks one line and reports its test when the test ends there.
  task automatic close_line(input int line);
    logic [31:0] test_id;
    test_id = case_words[line * FIELDS];
    check_line(line);
    if (line == n_lines - 1 || case_words[(line + 1) * FIELDS] != test_id) begin
      report_test($sformatf("Test %0d", test_id));
    end
  endtask

  initial begin
    void'($urandom(RAND_SEED));
    reset_n   = 1'b0;
    req_valid = '0;
    exp_valid = '0;
    for (int p = 0; p < `LSU_PORT_NUM; p++) begin
      req_op[p]    = OP_LOAD;
      req_addr[p]  = '0;
      req_wdata[p] = '0;
      exp_data[p]  = '0;
    end

    $readmemh("testbench/lsu_cases.txt", case_words);
    while (n_lines < MAX_LINES && case_words[n_lines * FIELDS] !== '0 &&
           !$isunknown(case_words[n_lines * FIELDS])) begin
      n_lines++;
    end
    cycle_limit = n_lines + 20;
    if (n_lines == 0) begin
      $display("No case lines could be read from the cases file");
      total_errors++;
    end

    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    check_reset_state();
    report_test("Reset state");
    reset_n = 1'b1;

    // Each falling edge checks the previous line, then drives the next.
    for (int line = 0; line < n_lines; line++) begin
      @(negedge clk);
      if (line > 0) begin
        close_line(line - 1);
      end
      drive_line(line);
    end
    if (n_lines > 0) begin
      @(negedge clk);
      close_line(n_lines - 1);
    end
    req_valid = '0;

    $display("Tests run: %0d, tests failed: %0d, check errors: %0d",
             tests_run, tests_failed, total_errors);
    if (tests_failed == 0 && total_errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: testbench/lsu_cases.txt
// test, then per port: flag op addr wdata expect (port 0 first, then port 1)
// flag 0 idle, 1 active, 2 store random data, 3 load word stored with random data
// op 0 load, 1 store, 2 LR, 3 SC
// Test 1: store then load on both ports, read during write sees old data
1 1 1 00000010 11112222 00000000 1 1 00000020 33334444 00000000
1 1 0 00000020 00000000 33334444 1 0 00000010 00000000 11112222
1 2 1 00000030 00000000 00000000 0 0 00000000 00000000 00000000
1 0 0 00000000 00000000 00000000 3 0 00000030 00000000 00000000
1 1 1 00000010 aaaa0001 00000000 1 0 00000010 00000000 11112222
1 0 0 00000000 00000000 00000000 1 0 00000010 00000000 aaaa0001
// Test 2: LR then SC to the same address succeeds on each port
2 1 1 00000040 00000040 00000000 0 0 00000000 00000000 00000000
2 1 2 00000040 00000000 00000040 0 0 00000000 00000000 00000000
2 1 3 00000040 5c5c0001 00000000 0 0 00000000 00000000 00000000
2 0 0 00000000 00000000 00000000 1 0 00000040 00000000 5c5c0001
2 0 0 00000000 00000000 00000000 1 1 00000044 00000044 00000000
2 0 0 00000000 00000000 00000000 1 2 00000044 00000000 00000044
2 0 0 00000000 00000000 00000000 1 3 00000044 5c5c0002 00000000
2 1 0 00000044 00000000 5c5c0002 0 0 00000000 00000000 00000000
// Test 3: SC with no reservation, or after a finished SC, fails
3 1 1 00000050 50505050 00000000 0 0 00000000 00000000 00000000
3 1 3 00000050 dead0001 00000001 0 0 00000000 00000000 00000000
3 1 0 00000050 00000000 50505050 0 0 00000000 00000000 00000000
3 0 0 00000000 00000000 00000000 1 2 00000050 00000000 50505050
3 0 0 00000000 00000000 00000000 1 3 00000050 beef0001 00000000
3 0 0 00000000 00000000 00000000 1 3 00000050 beef0002 00000001
3 1 0 00000050 00000000 beef0001 0 0 00000000 00000000 00000000
// Test 4: wrong address fails, a port 1 LR replaces the port 0 reservation
4 1 1 00000060 60606060 00000000 1 1 00000064 64646464 00000000
4 1 2 00000060 00000000 60606060 0 0 00000000 00000000 00000000
4 1 3 00000064 0bad0001 00000001 0 0 00000000 00000000 00000000
4 1 0 00000064 00000000 64646464 1 0 00000060 00000000 60606060
4 1 2 00000060 00000000 60606060 0 0 00000000 00000000 00000000
4 0 0 00000000 00000000 00000000 1 2 00000064 00000000 64646464
4 1 3 00000060 0bad0002 00000001 0 0 00000000 00000000 00000000
4 1 2 00000060 00000000 60606060 0 0 00000000 00000000 00000000
4 0 0 00000000 00000000 00000000 1 2 00000064 00000000 64646464
4 0 0 00000000 00000000 00000000 1 3 00000064 64640002 00000000
4 1 0 00000060 00000000 60606060 1 0 00000064 00000000 64640002
// Test 5: a plain store between LR and SC keeps the reservation
5 1 1 00000070 70707070 00000000 0 0 00000000 00000000 00000000
5 1 2 00000070 00000000 70707070 0 0 00000000 00000000 00000000
5 0 0 00000000 00000000 00000000 1 1 00000070 71717171 00000000
5 1 3 00000070 72727272 00000000 0 0 00000000 00000000 00000000
5 0 0 00000000 00000000 00000000 1 0 00000070 00000000 72727272
// Test 6: same-word stores keep port 1 data, dual loads in one cycle
6 1 1 00000080 0000aaaa 00000000 1 1 00000080 0000bbbb 00000000
6 1 0 00000080 00000000 0000bbbb 1 0 00000080 00000000 0000bbbb
6 2 1 00000084 00000000 00000000 2 1 00000088 00000000 00000000
6 3 0 00000088 00000000 00000000 3 0 00000084 00000000 00000000
// End of cases
0 0 0 00000000 00000000 00000000 0 0 00000000 00000000 00000000

// File: vlog.f
+incdir+src
src/lsu_pkg.sv
src/bit_oh_or.sv
src/lsu_lrsc.sv
src/lsu_port.sv
src/lsu_dmem.sv
src/lsu_top.sv
testbench/tb_lsu_top.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_lsu_top
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "ALL TESTS PASSED" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
